//--- src/mvm_params.svh
`ifndef MVM_PARAMS_SVH
`define MVM_PARAMS_SVH

// matrix rows, also the length of the input vector
`define ROWS 4

// matrix columns, one mac lane per column
`define COLS 4

// signed weight and vector element width
`define DATA_W 8

// signed accumulator width, holds ROWS products of two DATA_W values
`define ACC_W 24

// wishbone word address width
`define WB_ADR_W 8

`endif

//--- src/mvm_pkg.sv
`include "mvm_params.svh"

package mvm_pkg;

  // index widths, never below one bit
  localparam int ROW_W  = (`ROWS > 1) ? $clog2(`ROWS) : 1;
  localparam int COL_W  = (`COLS > 1) ? $clog2(`COLS) : 1;
  localparam int WIDX_W = (`ROWS * `COLS > 1) ? $clog2(`ROWS * `COLS) : 1;

  // signed matrix or vector element
  typedef logic signed [`DATA_W-1:0] data_t;

  // signed lane sum
  typedef logic signed [`ACC_W-1:0] acc_t;

  typedef logic [ROW_W-1:0] row_t;

  typedef logic [COL_W-1:0] col_t;

  // flat weight store index, row-major with column fastest
  typedef logic [WIDX_W-1:0] widx_t;

endpackage

//--- src/wb_mvm_port.sv
`include "mvm_params.svh"

module wb_mvm_port (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`WB_ADR_W-1:0]  adr,
  input  logic [31:0]           dat_w,
  output logic                  ack,
  output logic [31:0]           dat_r,
  input  logic                  busy,
  input  logic                  done,
  input  mvm_pkg::acc_t         result [`COLS],
  output logic                  start,
  input  mvm_pkg::widx_t        store_addr,
  input  logic                  store_en,
  output mvm_pkg::data_t        store_dout,
  output mvm_pkg::data_t        x_vec [`ROWS]
);

  localparam logic [1:0] REGION_WEIGHT = 2'd0;
  localparam logic [1:0] REGION_VECTOR = 2'd1;
  localparam logic [1:0] REGION_RESULT = 2'd2;
  localparam logic [1:0] REGION_CTRL   = 2'd3;

  logic [1:0]     region;
  logic           access;
  logic           wr_ok;
  logic           w_hit;
  logic           word0;
  mvm_pkg::widx_t w_idx;
  mvm_pkg::row_t  v_idx;
  mvm_pkg::col_t  r_idx;
  logic [31:0]    rd_word;

  // flat weight store, host writes and feeder reads
  mvm_pkg::data_t store [`ROWS*`COLS];

  assign region = adr[7:6];
  assign word0  = (adr[5:0] == 6'd0);
  assign w_hit  = (adr[5:0] < 6'(`ROWS * `COLS));
  assign w_idx  = adr[mvm_pkg::WIDX_W-1:0];
  assign v_idx  = adr[mvm_pkg::ROW_W-1:0];
  assign r_idx  = adr[mvm_pkg::COL_W-1:0];

  // ack one cycle after the strobe, then one idle cycle before the next
  assign access = cyc && stb && !ack;

  // weight and vector writes are dropped while a run is active
  assign wr_ok = access && we && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      start <= 1'b0;
    end else begin
      ack   <= access;
      start <= access && we && (region == REGION_CTRL) && word0 && !busy;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok && (region == REGION_WEIGHT) && w_hit) begin
      store[w_idx] <= dat_w[`DATA_W-1:0];
    end
  end

  // one cycle of read latency toward the feeder
  always_ff @(posedge clk) begin
    if (store_en) begin
      store_dout <= store[store_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok && (region == REGION_VECTOR)) begin
      x_vec[v_idx] <= dat_w[`DATA_W-1:0];
    end
  end

  // read mux, values sign-extended to the bus word
  always_comb begin
    rd_word = 32'd0;
    case (region)
      REGION_VECTOR: begin
        rd_word = {{(32-`DATA_W){x_vec[v_idx][`DATA_W-1]}}, x_vec[v_idx]};
      end
      REGION_RESULT: begin
        rd_word = {{(32-`ACC_W){result[r_idx][`ACC_W-1]}}, result[r_idx]};
      end
      REGION_CTRL: begin
        if (word0) begin
          rd_word = {30'd0, done, busy};
        end
      end
      default: begin
        // weights are write-only
        rd_word = 32'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (access && !we) begin
      dat_r <= rd_word;
    end
  end

endmodule

//--- src/lane_feeder.sv
`include "mvm_params.svh"

module lane_feeder (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  mvm_pkg::data_t     store_dout,
  input  mvm_pkg::data_t     x_vec [`ROWS],
  output logic               busy,
  output mvm_pkg::widx_t     store_addr,
  output logic               store_en,
  output logic [`COLS-1:0]   bank_we,
  output mvm_pkg::row_t      bank_addr,
  output mvm_pkg::data_t     bank_din,
  output logic               mac_clr,
  output logic               mac_en,
  output mvm_pkg::row_t      mac_row,
  output mvm_pkg::data_t     x_bcast,
  output logic               last
);

  localparam mvm_pkg::widx_t IDX_LAST = mvm_pkg::widx_t'(`ROWS * `COLS - 1);
  localparam mvm_pkg::row_t  ROW_LAST = mvm_pkg::row_t'(`ROWS - 1);
  localparam mvm_pkg::col_t  COL_LAST = mvm_pkg::col_t'(`COLS - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_COMP,
    ST_DRAIN
  } state_t;

  state_t         state;
  mvm_pkg::widx_t rd_addr;
  logic           rd_en;
  logic           rd_valid_q;
  mvm_pkg::row_t  wr_row;
  mvm_pkg::col_t  wr_col;
  mvm_pkg::row_t  row_q;
  logic           load_end;

  // final element lands in its bank this cycle
  assign load_end = rd_valid_q && (wr_row == ROW_LAST) && (wr_col == COL_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      rd_addr    <= '0;
      rd_en      <= 1'b0;
      rd_valid_q <= 1'b0;
      wr_row     <= '0;
      wr_col     <= '0;
      row_q      <= '0;
    end else begin
      // write side trails the read address by the store latency
      rd_valid_q <= rd_en;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state   <= ST_LOAD;
            rd_en   <= 1'b1;
            rd_addr <= '0;
            wr_row  <= '0;
            wr_col  <= '0;
          end
        end
        ST_LOAD: begin
          if (rd_en) begin
            if (rd_addr == IDX_LAST) begin
              rd_en <= 1'b0;
            end else begin
              rd_addr <= rd_addr + 1'b1;
            end
          end
          // column is the fastest index
          if (rd_valid_q && !load_end) begin
            if (wr_col == COL_LAST) begin
              wr_col <= '0;
              wr_row <= wr_row + 1'b1;
            end else begin
              wr_col <= wr_col + 1'b1;
            end
          end
          if (load_end) begin
            state <= ST_COMP;
            row_q <= '0;
          end
        end
        ST_COMP: begin
          if (row_q == ROW_LAST) begin
            state <= ST_DRAIN;
          end else begin
            row_q <= row_q + 1'b1;
          end
        end
        default: begin
          // collector takes the sums here
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    for (int c = 0; c < `COLS; c++) begin
      bank_we[c] = rd_valid_q && (wr_col == mvm_pkg::col_t'(c));
    end
  end

  assign busy       = (state != ST_IDLE);
  assign store_en   = rd_en;
  assign store_addr = rd_addr;
  assign bank_addr  = wr_row;
  assign bank_din   = store_dout;

  assign mac_en  = (state == ST_COMP);
  assign mac_clr = mac_en && (row_q == '0);
  assign mac_row = row_q;
  assign x_bcast = x_vec[row_q];
  assign last    = mac_en && (row_q == ROW_LAST);

endmodule

//--- src/mac_lane.sv
`include "mvm_params.svh"

module mac_lane (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           bank_we,
  input  mvm_pkg::row_t  bank_addr,
  input  mvm_pkg::data_t bank_din,
  input  logic           mac_clr,
  input  logic           mac_en,
  input  mvm_pkg::row_t  mac_row,
  input  mvm_pkg::data_t x_bcast,
  output mvm_pkg::acc_t  acc
);

  // weights of this column, one entry per row
  mvm_pkg::data_t bank [`ROWS];

  mvm_pkg::data_t              w_sel;
  logic signed [2*`DATA_W-1:0] prod;

  always_ff @(posedge clk) begin
    if (bank_we) begin
      bank[bank_addr] <= bank_din;
    end
  end

  // bank is read without a register
  assign w_sel = bank[mac_row];
  assign prod  = w_sel * x_bcast;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (mac_en) begin
      // first row loads instead of adding
      if (mac_clr) begin
        acc <= mvm_pkg::acc_t'(prod);
      end else begin
        acc <= acc + mvm_pkg::acc_t'(prod);
      end
    end
  end

endmodule

//--- src/result_collector.sv
`include "mvm_params.svh"

module result_collector (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,
  input  logic          last,
  input  mvm_pkg::acc_t lane_acc [`COLS],
  output mvm_pkg::acc_t result [`COLS],
  output logic          done
);

  // lane sums settle one cycle after the last product
  logic last_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q <= 1'b0;
    end else begin
      last_q <= last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < `COLS; c++) begin
        result[c] <= '0;
      end
    end else if (last_q) begin
      for (int c = 0; c < `COLS; c++) begin
        result[c] <= lane_acc[c];
      end
    end
  end

  // set with the latch, cleared by the next start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b0;
    end else if (last_q) begin
      done <= 1'b1;
    end
  end

endmodule

//--- src/mvm_top.sv
`include "mvm_params.svh"

module mvm_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [`WB_ADR_W-1:0] adr,
  input  logic [31:0]          dat_w,
  output logic [31:0]          dat_r,
  output logic                 ack
);

  logic               start;
  logic               busy;
  logic               done;
  mvm_pkg::widx_t     store_addr;
  logic               store_en;
  mvm_pkg::data_t     store_dout;
  mvm_pkg::data_t     x_vec [`ROWS];
  logic [`COLS-1:0]   bank_we;
  mvm_pkg::row_t      bank_addr;
  mvm_pkg::data_t     bank_din;
  logic               mac_clr;
  logic               mac_en;
  mvm_pkg::row_t      mac_row;
  mvm_pkg::data_t     x_bcast;
  logic               last;
  mvm_pkg::acc_t      lane_acc [`COLS];
  mvm_pkg::acc_t      result [`COLS];

  wb_mvm_port u_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .ack        (ack),
    .dat_r      (dat_r),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .start      (start),
    .store_addr (store_addr),
    .store_en   (store_en),
    .store_dout (store_dout),
    .x_vec      (x_vec)
  );

  lane_feeder u_feeder (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .store_dout (store_dout),
    .x_vec      (x_vec),
    .busy       (busy),
    .store_addr (store_addr),
    .store_en   (store_en),
    .bank_we    (bank_we),
    .bank_addr  (bank_addr),
    .bank_din   (bank_din),
    .mac_clr    (mac_clr),
    .mac_en     (mac_en),
    .mac_row    (mac_row),
    .x_bcast    (x_bcast),
    .last       (last)
  );

  // one lane per matrix column
  for (genvar c = 0; c < `COLS; c++) begin : g_lane
    mac_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .bank_we   (bank_we[c]),
      .bank_addr (bank_addr),
      .bank_din  (bank_din),
      .mac_clr   (mac_clr),
      .mac_en    (mac_en),
      .mac_row   (mac_row),
      .x_bcast   (x_bcast),
      .acc       (lane_acc[c])
    );
  end

  result_collector u_collector (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .last     (last),
    .lane_acc (lane_acc),
    .result   (result),
    .done     (done)
  );

endmodule

//--- test/tb_mvm.sv
`include "mvm_params.svh"

module tb_mvm;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NW         = `ROWS * `COLS;
  localparam int NCASE      = 5;
  localparam int NRAND      = 6;
  localparam int ACK_LIMIT  = 20;
  localparam int POLL_LIMIT = 100;
  localparam logic [`WB_ADR_W-1:0] CTRL_ADR = 8'hc0;

  logic                 clk;
  logic                 rst_n;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [`WB_ADR_W-1:0] adr;
  logic [31:0]          dat_w;
  logic [31:0]          dat_r;
  logic                 ack;

  // what the DUT should hold after the writes that are not dropped
  mvm_pkg::data_t w_model [NW];
  mvm_pkg::data_t x_model [`ROWS];

  // element 0 sits in the low byte, weights row-major with column fastest
  logic [NW*`DATA_W-1:0] case_w [NCASE] = '{
    128'h0f0e0d0c_0b0a0908_07060504_03020100,
    128'hf120e305_fa7c09c8_11ee40d7_029b66bf,
    128'h80808080_80808080_80808080_80808080,
    128'h7f817f81_817f817f_7f817f81_817f817f,
    128'h00000000_00000000_00000000_00000000
  };
  logic [`ROWS*`DATA_W-1:0] case_x [NCASE] = '{
    32'h04030201,
    32'hfd14880b,
    32'h80808080,
    32'h817f817f,
    32'hfe05807f
  };
  // 0 keeps the stored weights, only the vector is sent
  bit case_rw [NCASE] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

  mvm_top UUT (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  // one classic cycle, ack sampled on the falling edge
  task automatic bus_cycle(input bit wr, input logic [`WB_ADR_W-1:0] a,
                           input logic [31:0] d, output logic [31:0] q);
    int n;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    n = 0;
    @(negedge clk);
    while (!ack && n < ACK_LIMIT) begin
      n++;
      @(negedge clk);
    end
    if (!ack) begin
      stop_fail($sformatf("no ack from the Wishbone port for address %0h", a));
    end
    q = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [`WB_ADR_W-1:0] a, input logic [31:0] d);
    logic [31:0] unused_q;
    bus_cycle(1'b1, a, d, unused_q);
  endtask

  task automatic wb_read(input logic [`WB_ADR_W-1:0] a, output logic [31:0] q);
    bus_cycle(1'b0, a, 32'd0, q);
  endtask

  task automatic check_result(input int lane, input logic [31:0] got,
                              input mvm_pkg::acc_t exp);
    int exp_word;
    exp_word = exp;
    if (got !== exp_word) begin
      $display("CHECK FAILED at %0t: result[%0d] got %h expected %h",
               $time, lane, got, exp_word);
      stop_fail("lane result differs from the expected sum");
    end
  endtask

  task automatic check_status(input logic busy_exp, input logic done_exp);
    logic [31:0] q;
    wb_read(CTRL_ADR, q);
    if (q !== {30'd0, done_exp, busy_exp}) begin
      $display("CHECK FAILED at %0t: status got %h expected %h",
               $time, q, {30'd0, done_exp, busy_exp});
      stop_fail("status word differs from the expected busy and done bits");
    end
  endtask

  // y[c] is the sum over r of w[r][c] * x[r]
  function automatic mvm_pkg::acc_t expected_sum(input int c);
    int sum;
    sum = 0;
    for (int r = 0; r < `ROWS; r++) begin
      sum += int'(w_model[r*`COLS + c]) * int'(x_model[r]);
    end
    return mvm_pkg::acc_t'(sum);
  endfunction

  task automatic write_weights();
    for (int i = 0; i < NW; i++) begin
      wb_write({2'b00, 6'(i)}, 32'(w_model[i]));
    end
  endtask

  task automatic write_vector();
    for (int r = 0; r < `ROWS; r++) begin
      wb_write({2'b01, 6'(r)}, 32'(x_model[r]));
    end
  endtask

  task automatic wait_done();
    logic [31:0] q;
    int n;
    n = 0;
    wb_read(CTRL_ADR, q);
    while (!q[1] && n < POLL_LIMIT) begin
      n++;
      wb_read(CTRL_ADR, q);
    end
    if (!q[1]) begin
      stop_fail("run did not report done within the poll limit");
    end
  endtask

  task automatic check_all_results();
    logic [31:0] q;
    for (int c = 0; c < `COLS; c++) begin
      wb_read({2'b10, 6'(c)}, q);
      check_result(c, q, expected_sum(c));
    end
  endtask

  task automatic run_and_check(input bit restart);
    wb_write(CTRL_ADR, 32'd1);
    // a second start lands while busy and must be ignored
    if (restart) begin
      wb_write(CTRL_ADR, 32'd1);
    end
    wait_done();
    check_status(1'b0, 1'b1);
    check_all_results();
  endtask

  initial begin
    logic [31:0] q;
    void'($urandom(32'had1b_86e5));
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    check_status(1'b0, 1'b0);
    for (int c = 0; c < `COLS; c++) begin
      wb_read({2'b10, 6'(c)}, q);
      check_result(c, q, mvm_pkg::acc_t'(0));
    end

    for (int k = 0; k < NCASE; k++) begin
      if (case_rw[k]) begin
        for (int i = 0; i < NW; i++) begin
          w_model[i] = case_w[k][i*`DATA_W +: `DATA_W];
        end
        write_weights();
      end
      for (int r = 0; r < `ROWS; r++) begin
        x_model[r] = case_x[k][r*`DATA_W +: `DATA_W];
      end
      write_vector();
      run_and_check(!case_rw[k]);
    end

    // weight and vector writes during the run must be dropped
    wb_write(CTRL_ADR, 32'd1);
    check_status(1'b1, 1'b0);
    wb_write({2'b00, 6'd8}, 32'h0000_0055);
    wb_write({2'b01, 6'd0}, 32'h0000_0033);
    wb_write({2'b00, 6'(NW-1)}, 32'hffff_ff99);
    check_status(1'b1, 1'b0);
    wait_done();
    check_status(1'b0, 1'b1);
    check_all_results();

    for (int k = 0; k < NRAND; k++) begin
      for (int i = 0; i < NW; i++) begin
        w_model[i] = mvm_pkg::data_t'($urandom);
      end
      for (int r = 0; r < `ROWS; r++) begin
        x_model[r] = mvm_pkg::data_t'($urandom);
      end
      write_weights();
      write_vector();
      run_and_check(1'b0);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+src
src/mvm_pkg.sv
src/wb_mvm_port.sv
src/lane_feeder.sv
src/mac_lane.sv
src/result_collector.sv
src/mvm_top.sv
test/tb_mvm.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_mvm
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

# the run passes only when the pass message shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
